//--- verilog/floppy_io_pkg.sv
// floppy io shared definitions
`default_nettype none

package floppy_io_pkg;

    //////////////////////////////
    // address map and widths
    //////////////////////////////
    typedef logic [15:0] bus_addr_t;            // processor byte address
    typedef logic [15:0] bus_data_t;            // processor data word
    typedef logic [7:0]  byte_t;

    localparam logic [3:0] BMEM_HI_NIB = 4'hD;  // buffer window $d000-$d3ff
    localparam int         BMEM_WORDS  = 512;   // depth of each byte bank
    localparam int         BMEM_AW     = $clog2(BMEM_WORDS);

    localparam logic [7:0] IO_PAGE = 8'hFF;     // $ff00-$ffef, $fff0 up excluded

    //////////////////////////////
    // i/o port numbers
    //////////////////////////////
    localparam logic [7:0] PORT_JOY         = 8'd2;   // keyboard keys
    localparam logic [7:0] PORT_OSD_COMMAND = 8'd22;  // {romhold,f11,f12,hold}
    localparam logic [7:0] PORT_ROM_PAGE    = 8'd24;  // loader addr [21:16]
    localparam logic [7:0] PORT_ROM_ADDR    = 8'd26;  // loader addr [15:0], word port
    localparam logic [7:0] PORT_ROM_DATA    = 8'd28;  // data byte + write strobe
    localparam logic [7:0] PORT_WAVCTL      = 8'd30;  // playback control

    //////////////////////////////
    // wav player
    //////////////////////////////
    typedef enum logic [1:0] {
        RATE_44100 = 2'd0,
        RATE_22050 = 2'd1,
        RATE_48000 = 2'd2,
        RATE_2400  = 2'd3
    } wav_rate_t;

    localparam int PRESCALE = 4;        // clk / 4 feeds the rate divider

    // 24 MHz / 4 / rate
    localparam logic [11:0] TOP_44100 = 12'd136;
    localparam logic [11:0] TOP_22050 = 12'd272;
    localparam logic [11:0] TOP_48000 = 12'd125;
    localparam logic [11:0] TOP_2400  = 12'd2500;

    // wavctl register layout, bit 0 is en
    typedef struct packed {
        wav_rate_t rate;    // bits 3:2
        logic      ab;      // 0 plays even bytes, 1 plays odd bytes
        logic      en;      // playback enable
    } wavctl_t;

    typedef logic [5:0] rom_page_t;     // rom loader page, kvaz banks

endpackage

`default_nettype wire

//--- verilog/cpu_bus_if.sv
// processor bus bundle
`timescale 1ns/10ps
`default_nettype none

interface cpu_bus_if
    import floppy_io_pkg::*;
();

    bus_addr_t addr;        // byte address
    bus_data_t wdata;       // write data, both bytes
    logic      rd;          // single cycle read
    logic [1:0] wr;         // byte strobes {odd,even}

    // processor side, drives the bus
    modport master (
        output addr,
        output wdata,
        output rd,
        output wr
    );

    // decoding blocks, buffer / wav / io regs
    modport slave (
        input addr,
        input wdata,
        input rd,
        input wr
    );

endinterface

`default_nettype wire

//--- verilog/sample_buffer.sv
// sample and sector buffer
`timescale 1ns/10ps
`default_nettype none

module sample_buffer
    import floppy_io_pkg::*;
(
    input  wire                 clk,
    cpu_bus_if.slave            bus,
    input  wire                 i_wav_rd,       // playback read request
    input  wire [BMEM_AW-1:0]   i_wav_index,    // playback word index
    input  wire                 i_wav_ab,       // playback bank, 1 = odd
    output bus_data_t           o_rdata,
    output byte_t               o_wav_byte
);

    // cpu view: even byte -> bank 0 (buffer a), odd byte -> bank 1 (buffer b)
    // each bank picks its own address so the cpu can fill one half
    // while the other one plays

    logic                   bmem_sel;
    logic [1:0]             wav_hit;            // playback owns this bank
    logic [BMEM_AW-1:0]     bank_addr [2];
    logic [1:0]             bank_we;
    byte_t                  bank_q [2];
    logic                   cpu_rd_q;           // read data due this cycle
    logic                   wav_ab_q;           // bank of the pending playback read

    // $d000-$d3ff only
    assign bmem_sel = (bus.addr[15:12] == BMEM_HI_NIB) && (bus.addr[11:10] == 2'b00);

    ///////////////////////////////
    // byte banks
    ///////////////////////////////
    for (genvar b = 0; b < 2; b++)
    begin : g_bank
        byte_t mem [BMEM_WORDS];

        assign wav_hit[b] = i_wav_rd && (i_wav_ab == 1'(b));

        // playback wins on its own bank
        assign bank_addr[b] = wav_hit[b] ? i_wav_index : bus.addr[BMEM_AW:1];
        assign bank_we[b]   = bmem_sel && bus.wr[b] && !wav_hit[b];   // blocked write is lost

        always_ff @(posedge clk)
        begin
            if (bank_we[b])
                mem[bank_addr[b]] <= bus.wdata[8*b +: 8];
            bank_q[b] <= mem[bank_addr[b]];     // read first
        end
    end

    ///////////////////////////////
    // read returns
    ///////////////////////////////
    always_ff @(posedge clk)
    begin
        cpu_rd_q <= bmem_sel && bus.rd;
        if (i_wav_rd)
            wav_ab_q <= i_wav_ab;   // hold bank for the data cycle
    end

    // zero when no read is pending, top ors the returns
    assign o_rdata = cpu_rd_q ? {bank_q[1], bank_q[0]} : '0;

    assign o_wav_byte = wav_ab_q ? bank_q[1] : bank_q[0];

endmodule

`default_nettype wire

//--- verilog/wav_player.sv
// wav ping-pong player
`timescale 1ns/10ps
`default_nettype none

module wav_player
    import floppy_io_pkg::*;
(
    input  wire                 clk,
    input  wire                 reset_n,
    cpu_bus_if.slave            bus,
    output logic                o_wav_rd,       // buffer read request
    output logic [BMEM_AW-1:0]  o_wav_index,    // word index in the playing bank
    output logic                o_wav_ab,       // playing bank
    output wavctl_t             o_wavctl,       // for readback
    output byte_t               o_sample,
    input  wire byte_t          i_wav_byte      // buffer data, one cycle after rd
);

    localparam int PRE_W = $clog2(PRESCALE);

    logic                   io_sel;
    logic                   wavctl_wr;
    wavctl_t                wavctl;
    logic [PRE_W-1:0]       pre_cnt;
    logic                   pre_ce;
    logic [11:0]            div_top;
    logic [11:0]            div_cnt;
    logic                   tick;               // one per sample period
    logic [BMEM_AW-1:0]     index;
    logic [BMEM_AW-1:0]     index_next;
    logic                   rd_pend;            // step 1, read request out
    logic                   ld_pend;            // step 2, data back from buffer

    assign io_sel    = (bus.addr[15:8] == IO_PAGE) && (bus.addr[7:4] != 4'hF);
    assign wavctl_wr = io_sel && (bus.addr[7:0] == PORT_WAVCTL) && bus.wr[0];

    //////////////////////////////
    // rate generation
    //////////////////////////////
    always_comb
    begin
        case (wavctl.rate)
            RATE_44100: div_top = TOP_44100;
            RATE_22050: div_top = TOP_22050;
            RATE_48000: div_top = TOP_48000;
            default:    div_top = TOP_2400;
        endcase
    end

    assign pre_ce = (pre_cnt == '0);
    assign tick   = pre_ce && (div_cnt == '0);    // period PRESCALE * top

    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            pre_cnt <= '0;
            div_cnt <= '0;
        end
        else
        begin
            pre_cnt <= (pre_cnt == PRE_W'(PRESCALE - 1)) ? '0 : pre_cnt + 1'b1;   // free running
            if (pre_ce)
                div_cnt <= (div_cnt == div_top - 1'b1) ? '0 : div_cnt + 1'b1;
        end
    end

    //////////////////////////////
    // index, a/b and sample
    //////////////////////////////
    assign index_next = index + 1'b1;

    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            wavctl   <= '0;
            index    <= '0;
            rd_pend  <= 1'b0;
            ld_pend  <= 1'b0;
            o_sample <= '0;
        end
        else
        begin
            rd_pend <= 1'b0;
            ld_pend <= rd_pend;                 // buffer answers a cycle later

            if (tick && wavctl.en)
            begin
                index   <= index_next;          // advance first, then read
                rd_pend <= 1'b1;
                if (index_next == '0)
                    wavctl.ab <= ~wavctl.ab;    // wrapped, switch halves
            end

            if (ld_pend)
                o_sample <= i_wav_byte;

            // start/stop, restart from index 0
            if (wavctl_wr)
            begin
                wavctl <= wavctl_t'(bus.wdata[3:0]);
                index  <= '0;
            end
        end
    end

    assign o_wav_rd    = rd_pend;
    assign o_wav_index = index;
    assign o_wav_ab    = wavctl.ab;
    assign o_wavctl    = wavctl;

endmodule

`default_nettype wire

//--- verilog/io_regs.sv
// i/o register block
`timescale 1ns/10ps
`default_nettype none

module io_regs
    import floppy_io_pkg::*;
(
    input  wire             clk,
    input  wire             reset_n,
    cpu_bus_if.slave        bus,
    input  wire [5:0]       i_keys,         // {reserved,left,right,up,down,enter}
    input  wire wavctl_t    i_wavctl,
    output bus_data_t       o_rdata,
    output rom_page_t       o_rom_page,
    output logic [15:0]     o_rom_addr,
    output byte_t           o_rom_data,
    output logic            o_rom_wr,       // one cycle per data write
    output byte_t           o_osd_command
);

    logic       io_sel;
    logic [7:0] port;
    logic       page_wr;
    logic       addr_wr;
    logic       data_wr;
    logic       osd_wr;
    bus_data_t  rd_mux;
    bus_data_t  rdata_q;

    // $ff00-$ffef
    assign io_sel = (bus.addr[15:8] == IO_PAGE) && (bus.addr[7:4] != 4'hF);
    assign port   = bus.addr[7:0];

    //////////////////////////////
    // write decode
    //////////////////////////////
    assign page_wr = io_sel && (port == PORT_ROM_PAGE) && bus.wr[0];      // byte
    assign addr_wr = io_sel && (port[7:1] == PORT_ROM_ADDR[7:1]) && |bus.wr; // 26/27, word
    assign data_wr = io_sel && (port == PORT_ROM_DATA) && bus.wr[0];      // byte
    assign osd_wr  = io_sel && (port == PORT_OSD_COMMAND) && bus.wr[0];

    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            o_rom_page    <= '0;
            o_rom_addr    <= '0;
            o_rom_data    <= '0;
            o_rom_wr      <= 1'b0;
            o_osd_command <= '0;
        end
        else
        begin
            o_rom_wr <= data_wr;                // strobe lines up with the data
            if (page_wr)
                o_rom_page <= bus.wdata[5:0];
            if (addr_wr)
                o_rom_addr <= bus.wdata;        // whole word on either strobe
            if (data_wr)
                o_rom_data <= bus.wdata[7:0];
            if (osd_wr)
                o_osd_command <= bus.wdata[7:0];
        end
    end

    //////////////////////////////
    // readback
    //////////////////////////////
    always_comb
    begin
        case (port)
            PORT_JOY:    rd_mux = {10'h0, i_keys};
            PORT_WAVCTL: rd_mux = {14'h0, i_wavctl.ab, i_wavctl.en};
            default:     rd_mux = '0;
        endcase
    end

    // value taken in the rd cycle, zero otherwise
    always_ff @(posedge clk)
    begin
        if (!reset_n)
            rdata_q <= '0;
        else
            rdata_q <= (io_sel && bus.rd) ? rd_mux : '0;
    end

    assign o_rdata = rdata_q;

endmodule

`default_nettype wire

//--- verilog/floppy_io_top.sv
// floppy io controller top
`timescale 1ns/10ps
`default_nettype none

module floppy_io_top
    import floppy_io_pkg::*;
(
    input  wire             clk,
    input  wire             reset_n,

    // processor bus
    input  wire bus_addr_t  i_bus_addr,
    input  wire bus_data_t  i_bus_wdata,
    input  wire             i_bus_rd,
    input  wire [1:0]       i_bus_wr,
    output bus_data_t       o_bus_rdata,

    input  wire [5:0]       i_keys,

    output byte_t           o_wav_sample,

    // rom loader
    output logic            o_rom_hold,     // holds the host cpu during loading
    output logic [15:0]     o_rom_addr,
    output rom_page_t       o_rom_page,
    output byte_t           o_rom_data,
    output logic            o_rom_wr,
    output byte_t           o_osd_command
);

    logic               wav_rd;
    logic [BMEM_AW-1:0] wav_index;
    logic               wav_ab;
    byte_t              wav_byte;
    wavctl_t            wavctl;
    bus_data_t          buf_rdata;
    bus_data_t          io_rdata;

    cpu_bus_if u_bus ();

    assign u_bus.addr  = i_bus_addr;
    assign u_bus.wdata = i_bus_wdata;
    assign u_bus.rd    = i_bus_rd;
    assign u_bus.wr    = i_bus_wr;

    sample_buffer u_sample_buffer (
        .clk         (clk),
        .bus         (u_bus),
        .i_wav_rd    (wav_rd),
        .i_wav_index (wav_index),
        .i_wav_ab    (wav_ab),
        .o_rdata     (buf_rdata),
        .o_wav_byte  (wav_byte)
    );

    wav_player u_wav_player (
        .clk         (clk),
        .reset_n     (reset_n),
        .bus         (u_bus),
        .o_wav_rd    (wav_rd),
        .o_wav_index (wav_index),
        .o_wav_ab    (wav_ab),
        .o_wavctl    (wavctl),
        .o_sample    (o_wav_sample),
        .i_wav_byte  (wav_byte)
    );

    io_regs u_io_regs (
        .clk           (clk),
        .reset_n       (reset_n),
        .bus           (u_bus),
        .i_keys        (i_keys),
        .i_wavctl      (wavctl),
        .o_rdata       (io_rdata),
        .o_rom_page    (o_rom_page),
        .o_rom_addr    (o_rom_addr),
        .o_rom_data    (o_rom_data),
        .o_rom_wr      (o_rom_wr),
        .o_osd_command (o_osd_command)
    );

    assign o_bus_rdata = buf_rdata | io_rdata;  // idle returns are zero
    assign o_rom_hold  = o_osd_command[3];      // romhold bit

endmodule

`default_nettype wire

//--- verification/tb_clock_gen.sv
// testbench clock and reset
`timescale 1ns/10ps
`default_nettype none

module tb_clock_gen (
    output logic o_clk,
    output logic o_reset_n
);

    localparam int HALF_PERIOD  = 5;    // 10 ns clock
    localparam int RESET_CYCLES = 8;

    initial
    begin
        o_clk = 1'b0;
        forever #HALF_PERIOD o_clk = ~o_clk;
    end

    // sync reset, released just after an edge
    initial
    begin
        o_reset_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge o_clk);
        #1 o_reset_n = 1'b1;
    end

endmodule

`default_nettype wire

//--- verification/tb_floppy_io.sv
// floppy io testbench
`timescale 1ns/10ps
`default_nettype none

module tb_floppy_io
    import floppy_io_pkg::*;
();

    // playback of 520 samples dominates the cycle budget
    localparam int BUDGET_CYCLES   = 20 + 2 * 512 + 300 + 400 + 120 + 60 + 520 * 500;
    localparam int WATCHDOG_CYCLES = BUDGET_CYCLES + BUDGET_CYCLES / 5;    // +20 %

    logic           clk;
    logic           reset_n;
    bus_addr_t      bus_addr;
    bus_data_t      bus_wdata;
    logic           bus_rd;
    logic [1:0]     bus_wr;
    logic [5:0]     keys;
    bus_data_t      bus_rdata;
    byte_t          wav_sample;
    logic           rom_hold;
    logic [15:0]    rom_addr;
    rom_page_t      rom_page;
    byte_t          rom_data;
    logic           rom_wr;
    byte_t          osd_command;

    // reference model
    byte_t          mem_model [1024];   // byte view of $d000-$d3ff
    rom_page_t      m_page;
    logic [15:0]    m_addr;
    byte_t          m_data;
    integer         seed;

    tb_clock_gen u_clock_gen (
        .o_clk     (clk),
        .o_reset_n (reset_n)
    );

    floppy_io_top u_dut (
        .clk           (clk),
        .reset_n       (reset_n),
        .i_bus_addr    (bus_addr),
        .i_bus_wdata   (bus_wdata),
        .i_bus_rd      (bus_rd),
        .i_bus_wr      (bus_wr),
        .o_bus_rdata   (bus_rdata),
        .i_keys        (keys),
        .o_wav_sample  (wav_sample),
        .o_rom_hold    (rom_hold),
        .o_rom_addr    (rom_addr),
        .o_rom_page    (rom_page),
        .o_rom_data    (rom_data),
        .o_rom_wr      (rom_wr),
        .o_osd_command (osd_command)
    );

    //////////////////////////////
    // helpers
    //////////////////////////////
    function automatic logic [31:0] rand32();
        return $random(seed);
    endfunction

    // byte address of the n-th played sample
    function automatic logic [9:0] play_addr(int n);
        if (n < 511)
            return 10'((n + 1) * 2);        // even bank, index 1..511
        return 10'((n - 511) * 2 + 1);      // odd bank after the wrap
    endfunction

    task automatic stop_run(string msg);
        $display("%s", msg);
        $display("Result: FAILED");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_data(bus_data_t got, bus_data_t exp, string what);
        if (got !== exp)
            stop_run($sformatf("[FAIL] %0t: %s got %h expected %h", $time, what, got, exp));
    endtask

    task automatic check_byte(byte_t got, byte_t exp, string what);
        if (got !== exp)
            stop_run($sformatf("[FAIL] %0t: %s got %h expected %h", $time, what, got, exp));
    endtask

    task automatic check_rom(rom_page_t page, logic [15:0] addr, byte_t data);
        if (rom_page !== page || rom_addr !== addr || rom_data !== data)
            stop_run($sformatf("[FAIL] %0t: rom page/addr/data %h/%h/%h expected %h/%h/%h",
                $time, rom_page, rom_addr, rom_data, page, addr, data));
    endtask

    task automatic step();
        @(posedge clk);
        #1;                                 // outputs settled and inputs driven here
    endtask

    // one write cycle with no read pending
    task automatic bus_write(bus_addr_t a, bus_data_t d, logic [1:0] s);
        bus_addr  = a;
        bus_wdata = d;
        bus_wr    = s;
        step();
        bus_wr    = 2'b00;
        check_data(bus_rdata, '0, "rdata after write");
    endtask

    task automatic bus_read(bus_addr_t a, output bus_data_t d);
        bus_addr = a;
        bus_rd   = 1'b1;
        step();
        bus_rd   = 1'b0;
        d        = bus_rdata;               // cycle n+1
    endtask

    // whole buffer from the model on both strobes
    task automatic load_buffer();
        logic [8:0] w;
        for (int i = 0; i < BMEM_WORDS; i++)
        begin
            w = 9'(i);
            bus_write({6'b110100, w, 1'b0}, {mem_model[{w, 1'b1}], mem_model[{w, 1'b0}]},
                2'b11);
        end
    endtask

    //////////////////////////////
    // stimulus
    //////////////////////////////
    initial
    begin
        bus_data_t  d;
        logic [1:0] s;
        logic [9:0] off;
        logic       a0;
        logic       exp_wr;
        byte_t      cmd;
        wavctl_t    ctl;
        byte_t      prev;
        byte_t      last;
        int         wait_cyc;

        seed      = 32'h6138;
        bus_addr  = '0;
        bus_wdata = '0;
        bus_rd    = 1'b0;
        bus_wr    = 2'b00;
        keys      = '0;
        m_page    = '0;
        m_addr    = '0;
        m_data    = '0;

        // reset state
        @(posedge reset_n);
        check_data({15'h0, rom_wr}, 16'h0, "rom_wr after reset");
        check_data({15'h0, rom_hold}, 16'h0, "rom_hold after reset");
        check_byte(osd_command, 8'h00, "osd command after reset");
        check_byte(wav_sample, 8'h00, "wav sample after reset");
        check_rom('0, '0, '0);
        bus_read({IO_PAGE, PORT_WAVCTL}, d);
        check_data(d, 16'h0, "wavctl after reset");

        // buffer round trip with playback off
        for (int i = 0; i < 1024; i++)
        begin
            off            = 10'(i);
            mem_model[off] = byte_t'(rand32());
        end
        load_buffer();                      // no x left in the banks
        for (int i = 0; i < 300; i++)
        begin
            off = 10'(rand32());
            d   = bus_data_t'(rand32());
            s   = 2'(rand32() % 3 + 1);
            bus_write({6'b110100, off}, d, s);
            if (s[0])
                mem_model[{off[9:1], 1'b0}] = d[7:0];
            if (s[1])
                mem_model[{off[9:1], 1'b1}] = d[15:8];
        end
        for (int i = 0; i < 200; i++)
        begin
            off = 10'(rand32());
            bus_read({6'b110100, off}, d);
            check_data(d, {mem_model[{off[9:1], 1'b1}], mem_model[{off[9:1], 1'b0}]},
                "buffer read");
            if (rand32() % 2 == 0)
            begin
                step();                     // idle gap
                check_data(bus_rdata, '0, "rdata in idle cycle");
            end
        end

        // rom loader
        for (int i = 0; i < 60; i++)
        begin
            d      = bus_data_t'(rand32());
            exp_wr = 1'b0;
            case (rand32() % 3)
                0:
                begin
                    bus_write({IO_PAGE, PORT_ROM_PAGE}, d, 2'b01);
                    m_page = d[5:0];
                end
                1:
                begin
                    a0 = 1'(rand32());      // 26 or 27
                    s  = 2'(rand32() % 3 + 1);
                    bus_write({IO_PAGE, PORT_ROM_ADDR[7:1], a0}, d, s);
                    m_addr = d;             // whole word on any strobe
                end
                default:
                begin
                    bus_write({IO_PAGE, PORT_ROM_DATA}, d, 2'b01);
                    m_data = d[7:0];
                    exp_wr = 1'b1;
                end
            endcase
            check_data({15'h0, rom_wr}, {15'h0, exp_wr}, "rom_wr strobe");
            check_rom(m_page, m_addr, m_data);
            if (exp_wr)
            begin
                step();                     // strobe is one cycle only
                check_data({15'h0, rom_wr}, 16'h0, "rom_wr after strobe");
                check_rom(m_page, m_addr, m_data);
            end
        end

        // osd command, keys, wavctl readback
        for (int i = 0; i < 8; i++)
        begin
            cmd = byte_t'(rand32());
            bus_write({IO_PAGE, PORT_OSD_COMMAND}, {8'h00, cmd}, 2'b01);
            check_byte(osd_command, cmd, "osd command");
            check_data({15'h0, rom_hold}, {15'h0, cmd[3]}, "rom hold");
            keys = 6'(rand32());
            bus_read({IO_PAGE, PORT_JOY}, d);
            check_data(d, {10'h0, keys}, "keyboard readback");
            ctl = wavctl_t'(4'(rand32()));
            bus_write({IO_PAGE, PORT_WAVCTL}, {12'h0, ctl}, 2'b01);
            bus_read({IO_PAGE, PORT_WAVCTL}, d);
            check_data(d, {14'h0, ctl.ab, ctl.en}, "wavctl readback");
        end
        bus_write({IO_PAGE, PORT_WAVCTL}, 16'h0, 2'b01);   // stop playback
        step();
        step();

        // playback with neighbours in play order differing
        last = wav_sample;
        prev = last;
        for (int n = 0; n < 1023; n++)
        begin
            off = play_addr(n);
            do
                mem_model[off] = byte_t'(rand32());
            while (mem_model[off] == prev);
            prev = mem_model[off];
        end
        mem_model[0] = byte_t'(rand32());   // index 0 of even bank never plays
        load_buffer();
        bus_write({IO_PAGE, PORT_WAVCTL}, {12'h0, RATE_48000, 1'b0, 1'b1}, 2'b01);
        for (int n = 0; n < 520; n++)
        begin
            wait_cyc = 0;
            while (wav_sample == last)
            begin
                step();
                wait_cyc++;
                if (wait_cyc > 600)
                    stop_run("playback stalled, o_wav_sample did not change in 600 cycles");
            end
            check_byte(wav_sample, mem_model[play_addr(n)], "playback sample");
            if (n > 0)
                check_data(bus_data_t'(wait_cyc), 16'd500, "cycles between samples");
            last = wav_sample;
        end
        bus_read({IO_PAGE, PORT_WAVCTL}, d);
        check_data(d, 16'h0003, "wavctl after wrap");      // ab now 1
        bus_write({IO_PAGE, PORT_WAVCTL}, 16'h0, 2'b01);

        $display("Result: PASSED");
        $finish;
    end

    //////////////////////////////
    // watchdog
    //////////////////////////////
    initial
    begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        stop_run("watchdog expired, the run timed out");
    end

endmodule

`default_nettype wire

//--- vlog.f
verilog/floppy_io_pkg.sv
verilog/cpu_bus_if.sv
verilog/sample_buffer.sv
verilog/wav_player.sv
verilog/io_regs.sv
verilog/floppy_io_top.sv
verification/tb_clock_gen.sv
verification/tb_floppy_io.sv

//--- run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --timing --timescale 1ns/10ps --top-module tb_floppy_io \
    -f vlog.f -o tb_floppy_io &&
./obj_dir/tb_floppy_io | tee /dev/stderr | grep "Result: PASSED" > /dev/null &&
echo "simulation passed" ||
{ echo "simulation failed"; exit 1; }
